// File: hdl/pipe_trace_config.svh
////////////////////////////////////////
// Pipeline trace unit configuration
// Widths, buffer depth and APB offsets
////////////////////////////////////////

`ifndef PIPE_TRACE_CONFIG_SVH
`define PIPE_TRACE_CONFIG_SVH

`define PT_STAMP_W       16     // Cycle counter and stamp width
`define PT_SEQ_W         16     // Instruction sequence number width
`define PT_FLUSH_W       16     // Killed instruction counter width
`define PT_FIFO_DEPTH    8      // Retire records held
`define PT_LEVEL_W       4      // Fill level, must hold PT_FIFO_DEPTH
`define PT_OVF_W         8      // Saturating overflow counter

// APB register map, byte offsets
`define PT_REG_CTRL      8'h00  // bit0 enable, bit1 clear (self clearing)
`define PT_REG_STATUS    8'h04
`define PT_REG_FLUSH_CNT 8'h08
`define PT_REG_POP       8'h0C  // Any write drops the head record
`define PT_REG_SEQ       8'h10
`define PT_REG_PC        8'h14
`define PT_REG_ST_IF_ID  8'h18
`define PT_REG_ST_EX_MEM 8'h1C
`define PT_REG_ST_WB     8'h20

`endif

// File: hdl/pipe_trace_pkg.sv
////////////////////////////////////////
// Pipeline trace types
// Stage index and retire record layout
////////////////////////////////////////

`default_nettype none

`include "pipe_trace_config.svh"

package pipe_trace_pkg;

    ////////////////////////////////////////
    // Pipeline stages
    ////////////////////////////////////////

    localparam int N_STAGES = 5;

    // Also the index into the stamp array of a record
    typedef enum logic [2:0] {
        ST_IF  = 3'd0,          // Fetch
        ST_ID  = 3'd1,          // Decode
        ST_EX  = 3'd2,          // Execute
        ST_MEM = 3'd3,          // Memory
        ST_WB  = 3'd4           // Write-back
    } stage_e;

    ////////////////////////////////////////
    // Retire record
    ////////////////////////////////////////

    // 16 + 32 + 5 x 16 = 128 bits
    // Each stamp is the first cycle the instruction spent in that stage
    typedef struct packed {
        logic [`PT_SEQ_W-1:0]                   seq;  // Fetch order, from 0
        logic [31:0]                            pc;
        logic [N_STAGES-1:0][`PT_STAMP_W-1:0]   st;   // st[ST_WB] is the MSBs
    } retire_rec_t;

endpackage

`default_nettype wire

// File: hdl/stage_tracker.sv
////////////////////////////////////////
// Stage tracker
// Follows instructions through IF..WB, stamps each stage
////////////////////////////////////////

`default_nettype none

`include "pipe_trace_config.svh"

module stage_tracker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        enable,       // Trace on
    input  logic                        fetch_valid,
    input  logic                        stall,        // Holds every stage
    input  logic                        flush,        // Kills IF and ID
    input  logic [31:0]                 fetch_pc,
    output logic                        rec_valid,    // Instruction leaving WB
    output pipe_trace_pkg::retire_rec_t rec,
    output logic [`PT_FLUSH_W-1:0]      flush_cnt
);

    // Slot k is the register behind stage k, so the instruction in slot k
    // is working in stage k+1 and slot ST_WB holds one leaving write-back

    logic [`PT_STAMP_W-1:0]      stamp;       // Free running cycle count
    logic [`PT_SEQ_W-1:0]        next_seq;
    logic                        advance;     // Pipeline moves this cycle
    logic                        take;        // Fetch captured
    logic [1:0]                  n_killed;
    pipe_trace_pkg::retire_rec_t new_rec;

    logic                        slot_vld [pipe_trace_pkg::N_STAGES];
    pipe_trace_pkg::retire_rec_t slot_rec [pipe_trace_pkg::N_STAGES];

    assign advance = !stall;
    assign take    = advance && enable && fetch_valid;

    // Flush only counts on a moving cycle
    assign n_killed = flush ? ({1'b0, take} + {1'b0, slot_vld[pipe_trace_pkg::ST_IF]})
                            : 2'd0;

    // Fresh record, fetch now and decode next cycle
    always_comb begin
        new_rec                         = '0;
        new_rec.seq                     = next_seq;
        new_rec.pc                      = fetch_pc;
        new_rec.st[pipe_trace_pkg::ST_IF] = stamp;
        new_rec.st[pipe_trace_pkg::ST_ID] = stamp + 1'b1;
    end

    ////////////////////////////////////////
    // Control state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            stamp     <= '0;
            next_seq  <= '0;
            flush_cnt <= '0;
            for (int i = 0; i < pipe_trace_pkg::N_STAGES; i++) begin
                slot_vld[i] <= 1'b0;
            end
        end else begin
            stamp <= stamp + 1'b1;
            if (advance) begin
                if (take) begin
                    next_seq <= next_seq + 1'b1;  // A killed fetch still uses its number
                end
                // Youngest two become bubbles on flush
                slot_vld[pipe_trace_pkg::ST_IF] <= take && !flush;
                slot_vld[pipe_trace_pkg::ST_ID] <= slot_vld[pipe_trace_pkg::ST_IF] && !flush;
                for (int i = 2; i < pipe_trace_pkg::N_STAGES; i++) begin
                    slot_vld[i] <= slot_vld[i-1];
                end
                flush_cnt <= flush_cnt + n_killed;
            end
        end
    end

    ////////////////////////////////////////
    // Slot payload
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (advance) begin
            slot_rec[pipe_trace_pkg::ST_IF] <= new_rec;
            for (int i = 1; i < pipe_trace_pkg::N_STAGES; i++) begin
                slot_rec[i] <= slot_rec[i-1];
            end
            // Stamp the stage each moving slot starts next cycle
            // Slot ST_WB has all its stamps already
            for (int i = 1; i < pipe_trace_pkg::N_STAGES - 1; i++) begin
                slot_rec[i].st[i+1] <= stamp + 1'b1;
            end
        end
    end

    // Retire only on a moving cycle, a held WB slot waits for the stall to end
    assign rec_valid = slot_vld[pipe_trace_pkg::ST_WB] && advance;
    assign rec       = slot_rec[pipe_trace_pkg::ST_WB];

endmodule

`default_nettype wire

// File: hdl/trace_fifo.sv
////////////////////////////////////////
// Retire record buffer
// Circular FIFO, drops and counts on full
////////////////////////////////////////

`default_nettype none

`include "pipe_trace_config.svh"

module trace_fifo (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  pipe_trace_pkg::retire_rec_t push_rec,
    input  logic                        pop,
    input  logic                        clear,         // Empties, zeroes overflow
    output pipe_trace_pkg::retire_rec_t head_rec,      // Oldest record
    output logic [`PT_LEVEL_W-1:0]      level,
    output logic [`PT_OVF_W-1:0]        overflow_cnt   // Saturates
);

    localparam int PTR_W = $clog2(`PT_FIFO_DEPTH);

    pipe_trace_pkg::retire_rec_t mem [`PT_FIFO_DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic                        empty;
    logic                        full;
    logic                        do_pop;
    logic                        do_push;

    assign empty   = (level == '0);
    assign full    = (level == `PT_FIFO_DEPTH);
    assign do_pop  = pop && !empty;            // Pop on empty ignored
    assign do_push = push && (!full || do_pop); // Full plus pop frees a slot

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            level        <= '0;
            overflow_cnt <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`PT_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`PT_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;       // Both or neither
            endcase
            // Lost record
            if (push && !do_push && (overflow_cnt != '1)) begin
                overflow_cnt <= overflow_cnt + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    assign head_rec = mem[rd_ptr];

endmodule

`default_nettype wire

// File: hdl/apb_trace_regs.sv
////////////////////////////////////////
// APB register block for the trace unit
// Control, status and head record readout
////////////////////////////////////////

`default_nettype none

`include "pipe_trace_config.svh"

module apb_trace_regs (
    input  logic                        clk,
    input  logic                        rst,
    // APB slave
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [7:0]                  paddr,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    // Trace side
    output logic                        enable,
    output logic                        pop,
    output logic                        clear,
    input  pipe_trace_pkg::retire_rec_t head_rec,
    input  logic [`PT_LEVEL_W-1:0]      level,
    input  logic [`PT_OVF_W-1:0]        overflow_cnt,
    input  logic [`PT_FLUSH_W-1:0]      flush_cnt
);

    logic        acc;       // Access phase
    logic        wr_acc;
    logic        rd_acc;
    logic        addr_ok;   // Offset is in the map
    logic        has_rec;   // Buffer not empty
    logic [31:0] rd_data;

    assign acc     = psel && penable;
    assign wr_acc  = acc && pwrite;
    assign rd_acc  = acc && !pwrite;
    assign has_rec = (level != '0);

    assign pready  = 1'b1;                  // No wait states
    assign pslverr = acc && !addr_ok;

    // One cycle strobes, act at the end of the access cycle
    assign pop   = wr_acc && (paddr == `PT_REG_POP);
    assign clear = wr_acc && (paddr == `PT_REG_CTRL) && pwdata[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
        end else if (wr_acc && (paddr == `PT_REG_CTRL)) begin
            enable <= pwdata[0];
        end
    end

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////

    always_comb begin
        addr_ok = 1'b1;
        rd_data = '0;
        case (paddr)
            `PT_REG_CTRL:      rd_data[0] = enable;   // Clear bit reads 0
            `PT_REG_STATUS: begin
                rd_data[`PT_LEVEL_W-1:0] = level;
                rd_data[8 +: `PT_OVF_W]  = overflow_cnt;
            end
            `PT_REG_FLUSH_CNT: rd_data[`PT_FLUSH_W-1:0] = flush_cnt;
            `PT_REG_POP:       rd_data = '0;           // Write only
            // Record fields read zero while empty
            `PT_REG_SEQ:       if (has_rec) rd_data[`PT_SEQ_W-1:0] = head_rec.seq;
            `PT_REG_PC:        if (has_rec) rd_data = head_rec.pc;
            `PT_REG_ST_IF_ID: if (has_rec) begin
                rd_data[16 +: `PT_STAMP_W] = head_rec.st[pipe_trace_pkg::ST_IF];
                rd_data[0 +: `PT_STAMP_W]  = head_rec.st[pipe_trace_pkg::ST_ID];
            end
            `PT_REG_ST_EX_MEM: if (has_rec) begin
                rd_data[16 +: `PT_STAMP_W] = head_rec.st[pipe_trace_pkg::ST_EX];
                rd_data[0 +: `PT_STAMP_W]  = head_rec.st[pipe_trace_pkg::ST_MEM];
            end
            `PT_REG_ST_WB:     if (has_rec) rd_data[0 +: `PT_STAMP_W] =
                                   head_rec.st[pipe_trace_pkg::ST_WB];
            default:           addr_ok = 1'b0;        // Unmapped offset
        endcase
    end

    // Bus quiet outside read access
    assign prdata = rd_acc ? rd_data : '0;

endmodule

`default_nettype wire

// File: hdl/pipe_trace_top.sv
////////////////////////////////////////
// Pipeline trace unit top
// Tracker, record buffer and APB registers
////////////////////////////////////////

`default_nettype none

`include "pipe_trace_config.svh"

module pipe_trace_top (
    input  logic        clk,
    input  logic        rst,
    // CPU side
    input  logic        fetch_valid,
    input  logic [31:0] fetch_pc,
    input  logic        stall,
    input  logic        flush,
    // APB
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic                        enable;
    logic                        rec_valid;
    pipe_trace_pkg::retire_rec_t rec;
    logic [`PT_FLUSH_W-1:0]      flush_cnt;
    logic                        pop;
    logic                        clear;
    pipe_trace_pkg::retire_rec_t head_rec;
    logic [`PT_LEVEL_W-1:0]      level;
    logic [`PT_OVF_W-1:0]        overflow_cnt;

    stage_tracker i_tracker (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .flush       (flush),
        .fetch_pc    (fetch_pc),
        .rec_valid   (rec_valid),
        .rec         (rec),
        .flush_cnt   (flush_cnt)
    );

    // Never back-pressures the tracker
    trace_fifo i_fifo (
        .clk          (clk),
        .rst          (rst),
        .push         (rec_valid),
        .push_rec     (rec),
        .pop          (pop),
        .clear        (clear),
        .head_rec     (head_rec),
        .level        (level),
        .overflow_cnt (overflow_cnt)
    );

    apb_trace_regs i_regs (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .enable       (enable),
        .pop          (pop),
        .clear        (clear),
        .head_rec     (head_rec),
        .level        (level),
        .overflow_cnt (overflow_cnt),
        .flush_cnt    (flush_cnt)
    );

endmodule

`default_nettype wire

// File: verification/pipe_trace_properties.sv
////////////////////////////////////////
// Stage tracker properties
// Record order and retire rules checked inside the tracker
////////////////////////////////////////

`default_nettype none

`include "pipe_trace_config.svh"

module pipe_trace_properties (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic                        wb_vld,       // Slot leaving write-back holds an instruction
    input  logic                        rec_valid,
    input  pipe_trace_pkg::retire_rec_t rec
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [`PT_SEQ_W-1:0] last_seq;   // Sequence number of the previous record
    logic                 seen;       // At least one record since reset

    always_ff @(posedge clk) begin
        if (rst) begin
            last_seq <= '0;
            seen     <= 1'b0;
        end else if (rec_valid) begin
            last_seq <= rec.seq;
            seen     <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    // Each stage entered no earlier than the one before
    a_stamps_ordered: assert property (@(posedge clk) disable iff (rst)
        rec_valid |-> (rec.st[pipe_trace_pkg::ST_ID]  >= rec.st[pipe_trace_pkg::ST_IF])
                   && (rec.st[pipe_trace_pkg::ST_EX]  >= rec.st[pipe_trace_pkg::ST_ID])
                   && (rec.st[pipe_trace_pkg::ST_MEM] >= rec.st[pipe_trace_pkg::ST_EX])
                   && (rec.st[pipe_trace_pkg::ST_WB]  >= rec.st[pipe_trace_pkg::ST_MEM]))
        else $error("stamps in a retire record decrease");

    a_quiet_after_reset: assert property (@(posedge clk) rst |=> !rec_valid)
        else $error("rec_valid high in the cycle after reset");

    // A stall holds back the record leaving write-back until the pipeline moves
    a_no_retire_on_stall: assert property (@(posedge clk) disable iff (rst)
        (stall && wb_vld) |-> !rec_valid ##1 (stall || rec_valid))
        else $error("record emitted on a stalled cycle or lost across the stall");

    a_seq_rising: assert property (@(posedge clk) disable iff (rst)
        (rec_valid && seen) |-> (rec.seq > last_seq))
        else $error("sequence number did not increase");

endmodule

bind stage_tracker pipe_trace_properties i_props (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .wb_vld    (slot_vld[pipe_trace_pkg::ST_WB]),
    .rec_valid (rec_valid),
    .rec       (rec)
);

`default_nettype wire

// File: verification/pipe_trace_tb.sv
////////////////////////////////////////
// Pipeline trace unit testbench
// Replays the stim file on the CPU side and over APB
////////////////////////////////////////

`default_nettype none

module pipe_trace_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst;
    logic        fetch_valid;
    logic [31:0] fetch_pc;
    logic        stall;
    logic        flush;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Parsed stimulus with one entry per command
    byte         cmd_op [$];
    logic [31:0] cmd_a  [$];
    logic [31:0] cmd_b  [$];
    logic [31:0] cmd_c  [$];
    logic [31:0] cmd_d  [$];
    logic [31:0] cmd_e  [$];

    int stim_lines  = 0;    // Watchdog length
    int errors      = 0;
    int checks      = 0;
    int test_errs   = 0;
    int test_checks = 0;
    int tests       = 0;

    pipe_trace_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .stall       (stall),
        .flush       (flush),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic string reg_name(input logic [7:0] addr);
        case (addr)
            8'h00:   return "CTRL";
            8'h04:   return "STATUS";
            8'h08:   return "FLUSH_CNT";
            8'h0C:   return "POP";
            8'h10:   return "SEQ";
            8'h14:   return "PC";
            8'h18:   return "ST_IF_ID";
            8'h1C:   return "ST_EX_MEM";
            8'h20:   return "ST_WB";
            default: return "UNMAPPED";
        endcase
    endfunction

    task automatic load_stim();
        int    fd;
        int    n;
        string line;
        byte   op;
        logic [31:0] a, b, c, d, e;
        fd = $fopen("verification/pipe_trace_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0) begin
                stim_lines++;
                if (line.len() > 1 && line[0] != "#") begin
                    a = '0;
                    b = '0;
                    c = '0;
                    d = '0;
                    e = '0;
                    n = $sscanf(line, "%c %h %h %h %h %h", op, a, b, c, d, e);
                    cmd_op.push_back(op);
                    cmd_a.push_back(a);
                    cmd_b.push_back(b);
                    cmd_c.push_back(c);
                    cmd_d.push_back(d);
                    cmd_e.push_back(e);
                end
            end
        end
        $fclose(fd);
    endtask

    // CPU side cycles with the PC stepping by 4 on each repeat
    task automatic cpu_cycles(input logic fv, input logic [31:0] pc, input logic st,
                              input logic fl, input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            fetch_valid <= fv;
            fetch_pc    <= pc + 32'(4 * i);
            stall       <= st;
            flush       <= fl;
            psel        <= 1'b0;
            penable     <= 1'b0;
        end
    endtask

    // Setup phase then access phase with no wait states
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        fetch_valid <= 1'b0;      // CPU idle while the pipeline still moves
        stall       <= 1'b0;
        flush       <= 1'b0;
        psel        <= 1'b1;
        penable     <= 1'b0;
        pwrite      <= wr;
        paddr       <= addr;
        pwdata      <= data;
        @(posedge clk);
        penable     <= 1'b1;
        @(negedge clk);           // Mid access cycle
        rdata = prdata;
        err   = pslverr;
        check_value("pready", 32'h1, {31'h0, pready});
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        test_checks++;
        if (got !== exp) begin
            $display("[ERROR] %s expected 0x%08h read 0x%08h", name, exp, got);
            errors++;
            test_errs++;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] rdata;
        logic        err;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        load_stim();
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (int k = 0; k < cmd_op.size(); k++) begin
            case (cmd_op[k])
                "C": cpu_cycles(cmd_a[k][0], cmd_b[k], cmd_c[k][0], cmd_d[k][0], cmd_e[k]);
                "W": apb_access(1'b1, cmd_a[k][7:0], cmd_b[k], rdata, err);
                "R": begin
                    apb_access(1'b0, cmd_a[k][7:0], '0, rdata, err);
                    check_value(reg_name(cmd_a[k][7:0]), cmd_b[k], rdata);
                    check_value("pslverr", 32'h0, {31'h0, err});
                end
                "X": begin                    // Expect an error response
                    apb_access(1'b0, cmd_a[k][7:0], '0, rdata, err);
                    check_value("pslverr", 32'h1, {31'h0, err});
                end
                "T": begin
                    tests++;
                    $display("Test %0d done: %0d checks, %0d errors",
                             cmd_a[k], test_checks, test_errs);
                    test_checks = 0;
                    test_errs   = 0;
                end
                default: begin
                    $display("Unknown stimulus command at entry %0d", k);
                    errors++;
                end
            endcase
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        @(posedge clk);

        if (tests == 0) begin
            $display("No test ran, the stimulus file is empty or missing");
            errors++;
        end
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the stimulus length
    initial begin
        wait (stim_lines > 0);
        #((stim_lines + 200) * 20);
        $display("Watchdog timeout, the stimulus did not complete");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/pipe_trace_stim.txt
# C fetch_valid pc stall flush count | W addr data | R addr expected | X addr (expect pslverr)
# T test_number marks the end of a test, all fields hex
C 1 00001000 0 0 2
C 0 00000000 0 0 6
R 04 00000000
T 1
W 00 00000001
C 1 00002000 0 0 1
C 0 00000000 0 0 5
R 04 00000001
R 10 00000000
R 14 00002000
R 18 000d000e
R 1c 000f0010
R 20 00000011
W 0c 00000000
R 04 00000000
T 2
C 1 00003000 0 0 1
C 0 00000000 0 0 1
C 0 00000000 1 0 3
C 0 00000000 0 0 3
R 18 00230024
R 1c 00250029
R 20 0000002a
R 10 00000001
W 0c 00000000
T 3
C 1 00004000 0 0 3
C 1 0000400c 0 1 1
C 0 00000000 0 0 3
R 08 00000002
R 04 00000002
R 10 00000002
R 18 00350036
W 0c 00000000
R 10 00000003
R 20 0000003a
W 0c 00000000
R 04 00000000
T 4
C 1 00005000 0 0 c
C 0 00000000 0 0 5
R 04 00000408
R 10 00000006
W 00 00000003
R 04 00000000
T 5
X 40
T 6

// File: src.f
+incdir+hdl
hdl/pipe_trace_pkg.sv
hdl/stage_tracker.sv
hdl/trace_fifo.sv
hdl/apb_trace_regs.sv
hdl/pipe_trace_top.sv
verification/pipe_trace_properties.sv
verification/pipe_trace_tb.sv

// File: Bender.yml
package:
  name: pipe_trace

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/pipe_trace_pkg.sv
      - hdl/stage_tracker.sv
      - hdl/trace_fifo.sv
      - hdl/apb_trace_regs.sv
      - hdl/pipe_trace_top.sv
  - target: test
    files:
      - verification/pipe_trace_properties.sv
      - verification/pipe_trace_tb.sv
